//--- src.f
core_pkg.sv
reg_file.sv
fetch_unit.sv
execute_unit.sv
load_store_unit.sv
bus_arbiter.sv
core_top.sv
tb_mem_model.sv
tb_core_top.sv

//--- Bender.yml
package:
  name: rv64i_core

sources:
  - core_pkg.sv
  - reg_file.sv
  - fetch_unit.sv
  - execute_unit.sv
  - load_store_unit.sv
  - bus_arbiter.sv
  - core_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_core_top.sv

//--- tb_core_top.sv
`timescale 1ns/100ps
module tb_core_top import core_pkg::*; ();
    logic     clk;
    logic     reset;
    logic     bus_req_valid;
    bus_req_t bus_req;
    logic     bus_req_ready;
    logic     bus_rsp_valid;
    xlen_t    bus_rsp_data;
    logic     wb_valid;
    wb_t      wb;
    int       ready_delay;
    logic     rand_en;

    int       errors;
    // observed and expected register writes
    wb_t      wb_seen [$];
    wb_t      wb_exp [$];
    wb_t      wb_first [$];
    inst_t    prog [$];
    // architectural state predicted from the instruction semantics
    xlen_t    ref_regs [32];
    xlen_t    ref_mem [64];

    core_top core_top_inst (
        .clk           (clk),
        .reset         (reset),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_req_ready (bus_req_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_data  (bus_rsp_data),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

    tb_mem_model mem_model (
        .clk         (clk),
        .reset       (reset),
        .ready_delay (ready_delay),
        .rand_en     (rand_en),
        .req_valid   (bus_req_valid),
        .req         (bus_req),
        .req_ready   (bus_req_ready),
        .rsp_valid   (bus_rsp_valid),
        .rsp_data    (bus_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every register write leaving the core
    always @(posedge clk) begin
        if (!reset && wb_valid) begin
            wb_seen.push_back(wb);
        end
    end

    // ------------------------------------------------------------
    // instruction encoding
    // ------------------------------------------------------------
    function automatic inst_t itype_word(input longint imm, input int rs1,
                                         input logic [2:0] funct3, input int rd,
                                         input logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic inst_t rtype_word(input logic [6:0] funct7, input int rs2,
                                         input int rs1, input int rd);
        return {funct7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic inst_t stype_word(input longint imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t btype_word(input longint off, input int rs2, input int rs1);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    // background memory contents
    function automatic xlen_t fill_word(input int idx);
        return {32'hc0de_0000 | 32'(idx), 32'(idx) * 32'h0101_0101};
    endfunction

    // ------------------------------------------------------------
    // program building with the reference state
    // ------------------------------------------------------------
    task automatic clear_program();
        prog.delete();
        wb_exp.delete();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = fill_word(i);
        end
    endtask

    // x0 still shows on the port but keeps reading zero
    task automatic expect_write(input int rd, input xlen_t value);
        wb_t e;
        e.rd   = rd[4:0];
        e.data = value;
        wb_exp.push_back(e);
        if (rd != 0) begin
            ref_regs[rd] = value;
        end
    endtask

    task automatic addi_step(input int rd, input int rs1, input longint imm);
        prog.push_back(itype_word(imm, rs1, 3'b000, rd, 7'b0010011));
        expect_write(rd, ref_regs[rs1] + xlen_t'(imm));
    endtask

    task automatic add_step(input int rd, input int rs1, input int rs2);
        prog.push_back(rtype_word(7'b0000000, rs2, rs1, rd));
        expect_write(rd, ref_regs[rs1] + ref_regs[rs2]);
    endtask

    task automatic sub_step(input int rd, input int rs1, input int rs2);
        prog.push_back(rtype_word(7'b0100000, rs2, rs1, rd));
        expect_write(rd, ref_regs[rs1] - ref_regs[rs2]);
    endtask

    task automatic ld_step(input int rd, input int rs1, input longint imm);
        xlen_t addr;
        addr = ref_regs[rs1] + xlen_t'(imm);
        prog.push_back(itype_word(imm, rs1, 3'b011, rd, 7'b0000011));
        expect_write(rd, ref_mem[addr[8:3]]);
    endtask

    task automatic sd_step(input int rs2, input int rs1, input longint imm);
        xlen_t addr;
        addr = ref_regs[rs1] + xlen_t'(imm);
        prog.push_back(stype_word(imm, rs2, rs1));
        ref_mem[addr[8:3]] = ref_regs[rs2];
    endtask

    task automatic beq_step(input int rs1, input int rs2, input longint off,
                            output logic taken);
        prog.push_back(btype_word(off, rs2, rs1));
        taken = (ref_regs[rs1] == ref_regs[rs2]);
    endtask

    // the two instructions after a beq, retired only on fall-through
    task automatic branch_shadow(input logic taken, input int rd_a, input int rd_b);
        if (taken) begin
            // jumped over so they never retire
            prog.push_back(itype_word(rd_a, 0, 3'b000, rd_a, 7'b0010011));
            prog.push_back(itype_word(rd_b, 0, 3'b000, rd_b, 7'b0010011));
        end else begin
            addi_step(rd_a, 0, rd_a);
            addi_step(rd_b, 0, rd_b);
        end
    endtask

    // ------------------------------------------------------------
    // run and check
    // ------------------------------------------------------------
    // reset for 2 cycles and load the image while the core is held
    task automatic reset_core(input int delay, input logic stalls);
        xlen_t image [64];
        @(posedge clk);
        reset       <= 1'b1;
        ready_delay <= delay;
        rand_en     <= stalls;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            image[i] = fill_word(i);
        end
        // two instructions per word with the lower half first
        foreach (prog[j]) begin
            image[j / 2][(j % 2) * 32 +: 32] = prog[j];
            ref_mem[j / 2][(j % 2) * 32 +: 32] = prog[j];
        end
        for (int i = 0; i < 64; i++) begin
            mem_model.mem[i] = image[i];
        end
        wb_seen.delete();
        reset <= 1'b0;
    endtask

    task automatic run_program(input int delay, input logic stalls);
        int cycles;
        // final self-loop keeps the core busy without writes
        prog.push_back(btype_word(0, 0, 0));
        reset_core(delay, stalls);
        cycles = 0;
        while (wb_seen.size() < wb_exp.size() && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (wb_seen.size() < wb_exp.size()) begin
            $display("timeout: only %0d of %0d register writes seen after %0d cycles",
                     wb_seen.size(), wb_exp.size(), cycles);
            errors++;
        end
        // let any unexpected extra write show up
        repeat (100) @(posedge clk);
    endtask

    task automatic compare_writes(input string name, input wb_t ref_q [$]);
        if (wb_seen.size() != ref_q.size()) begin
            $display("Mismatch at %0t: %s saw %0d register writes, expected %0d",
                     $time, name, wb_seen.size(), ref_q.size());
            errors++;
        end
        for (int i = 0; i < ref_q.size() && i < wb_seen.size(); i++) begin
            if (wb_seen[i] !== ref_q[i]) begin
                $display("Mismatch at %0t: %s write %0d got x%0d=%h, expected x%0d=%h",
                         $time, name, i, wb_seen[i].rd, wb_seen[i].data,
                         ref_q[i].rd, ref_q[i].data);
                errors++;
            end
        end
    endtask

    task automatic check_memory(input string name);
        for (int i = 0; i < 64; i++) begin
            if (mem_model.mem[i] !== ref_mem[i]) begin
                $display("Mismatch at %0t: %s memory word %0d is %h, expected %h",
                         $time, name, i, mem_model.mem[i], ref_mem[i]);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic arithmetic_test();
        clear_program();
        addi_step(1, 0, 5);
        addi_step(2, 0, -3);
        add_step(3, 1, 2);
        sub_step(4, 2, 1);
        // write to x0 then read it back
        addi_step(0, 1, 7);
        add_step(5, 0, 1);
        sub_step(6, 0, 3);
        addi_step(7, 4, -2048);
        run_program(0, 1'b0);
        compare_writes("arithmetic", wb_exp);
    endtask

    task automatic store_load_test(input logic stalls);
        clear_program();
        addi_step(1, 0, 320);
        addi_step(2, 0, -1234);
        sd_step(2, 1, 8);
        ld_step(3, 1, 8);
        addi_step(4, 3, 1);
        sd_step(4, 1, 16);
        ld_step(5, 1, 0);
        run_program(stalls ? 1 : 0, stalls);
        compare_writes(stalls ? "back-pressure" : "store/load", wb_exp);
        check_memory(stalls ? "back-pressure" : "store/load");
        // stalled run must match the clean one
        if (!stalls) begin
            wb_first = wb_seen;
        end else begin
            compare_writes("back-pressure vs clean run", wb_first);
        end
    endtask

    task automatic load_use_test();
        clear_program();
        ld_step(1, 0, 336);
        add_step(2, 1, 1);
        sub_step(3, 2, 1);
        run_program(6, 1'b0);
        compare_writes("load-use", wb_exp);
    endtask

    task automatic branch_test();
        logic taken;
        clear_program();
        addi_step(1, 0, 9);
        addi_step(2, 0, 9);
        // equal operands so the next pair is skipped
        beq_step(1, 2, 12, taken);
        branch_shadow(taken, 3, 4);
        addi_step(5, 0, 3);
        addi_step(6, 0, 4);
        // unequal operands so both followers retire
        beq_step(1, 6, 12, taken);
        branch_shadow(taken, 7, 8);
        run_program(0, 1'b0);
        compare_writes("branch", wb_exp);
        foreach (wb_seen[i]) begin
            if (wb_seen[i].rd == 5'd3 || wb_seen[i].rd == 5'd4) begin
                $display("Mismatch at %0t: branch wrote x%0d from a skipped instruction",
                         $time, wb_seen[i].rd);
                errors++;
            end
        end
    endtask

    initial begin
        errors      = 0;
        reset       = 1'b1;
        ready_delay = 0;
        rand_en     = 1'b0;
        arithmetic_test();
        store_load_test(1'b0);
        load_use_test();
        branch_test();
        store_load_test(1'b1);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/100ps
module tb_mem_model import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  int       ready_delay,
    input  logic     rand_en,
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output xlen_t    rsp_data
);
    // 64 words of 64 bits, indexed by address bits 8:3
    xlen_t  mem [64];
    integer seed;
    int     wait_cnt;
    int     rsp_wait;
    logic   pending;
    xlen_t  pending_data;
    xlen_t  read_data;
    int     gap;

    initial begin
        seed      = 32'hb324_4f4b;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
    end

    always @(posedge clk) begin
        rsp_valid <= 1'b0;
        if (reset) begin
            req_ready <= 1'b0;
            pending   <= 1'b0;
            wait_cnt  <= 0;
        end else if (req_valid && req_ready) begin
            // transfer, a write answers with zero data
            req_ready <= 1'b0;
            wait_cnt  <= 0;
            read_data = req.write ? '0 : mem[req.addr[8:3]];
            if (req.write) begin
                mem[req.addr[8:3]] <= req.wdata;
            end
            gap = rand_en ? ($random(seed) & 3) : 0;
            // no gap means the response shows in the next cycle
            if (gap == 0) begin
                rsp_valid <= 1'b1;
                rsp_data  <= read_data;
            end else begin
                pending      <= 1'b1;
                rsp_wait     <= gap;
                pending_data <= read_data;
            end
        end else if (pending) begin
            rsp_wait <= rsp_wait - 1;
            if (rsp_wait == 1) begin
                rsp_valid <= 1'b1;
                rsp_data  <= pending_data;
                pending   <= 1'b0;
            end
        end else if (req_valid) begin
            // ready after the programmed delay, randomly held off when enabled
            wait_cnt  <= wait_cnt + 1;
            req_ready <= (wait_cnt >= ready_delay) && (!rand_en || ($random(seed) & 1) != 0);
        end else begin
            wait_cnt  <= 0;
            req_ready <= 1'b0;
        end
    end

endmodule

//--- core_top.sv
`timescale 1ns/100ps
module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output logic     bus_req_valid,
    output bus_req_t bus_req,
    input  logic     bus_req_ready,
    input  logic     bus_rsp_valid,
    input  xlen_t    bus_rsp_data,
    output logic     wb_valid,
    output wb_t      wb
);
    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    logic       i_req_valid;
    bus_req_t   i_req;
    logic       i_req_ready;
    logic       i_rsp_valid;
    logic       d_req_valid;
    bus_req_t   d_req;
    logic       d_req_ready;
    logic       d_rsp_valid;
    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       fetch_ready;
    logic       redirect;
    xlen_t      redirect_pc;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      rdata1;
    xlen_t      rdata2;
    logic       mop_valid;
    mem_op_t    mop;
    logic       mop_ready;
    logic       load_valid;
    wb_t        load_wb;

    // instruction master
    fetch_unit fetch_unit_inst (
        .*,
        .req_valid (i_req_valid),
        .req       (i_req),
        .req_ready (i_req_ready),
        .rsp_valid (i_rsp_valid),
        .rsp_data  (bus_rsp_data)
    );

    execute_unit execute_unit_inst (.*);

    reg_file reg_file_inst (.*);

    // data master
    load_store_unit load_store_unit_inst (
        .*,
        .req_valid (d_req_valid),
        .req       (d_req),
        .req_ready (d_req_ready),
        .rsp_valid (d_rsp_valid),
        .rsp_data  (bus_rsp_data)
    );

    // response data is shared, only the valid is steered
    bus_arbiter bus_arbiter_inst (.*);

endmodule

//--- bus_arbiter.sv
`timescale 1ns/100ps
module bus_arbiter import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     d_req_valid,
    input  bus_req_t d_req,
    output logic     d_req_ready,
    output logic     d_rsp_valid,
    input  logic     i_req_valid,
    input  bus_req_t i_req,
    output logic     i_req_ready,
    output logic     i_rsp_valid,
    output logic     bus_req_valid,
    output bus_req_t bus_req,
    input  logic     bus_req_ready,
    input  logic     bus_rsp_valid
);
    arb_state_t state;
    logic       i_locked;
    logic       sel_d;
    logic       idle;

    assign idle = (state == ARB_IDLE);

    // data master first unless an instruction request is already on the bus
    assign sel_d = d_req_valid && !i_locked;

    assign bus_req_valid = idle && (d_req_valid || i_req_valid);
    assign bus_req       = sel_d ? d_req : i_req;
    assign d_req_ready   = idle && bus_req_ready && sel_d;
    assign i_req_ready   = idle && bus_req_ready && !sel_d;

    // response goes back to the owner only
    assign d_rsp_valid = (state == ARB_WAIT_D) && bus_rsp_valid;
    assign i_rsp_valid = (state == ARB_WAIT_I) && bus_rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ARB_IDLE;
            i_locked <= 1'b0;
        end else begin
            // keep an unaccepted instruction request on the bus
            if (bus_req_valid) begin
                i_locked <= !bus_req_ready && !sel_d;
            end
            case (state)
                ARB_IDLE: begin
                    if (bus_req_valid && bus_req_ready) begin
                        state <= sel_d ? ARB_WAIT_D : ARB_WAIT_I;
                    end
                end
                default: begin
                    if (bus_rsp_valid) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    a_no_idle_rsp: assert property (@(posedge clk) disable iff (reset)
        bus_rsp_valid |-> !idle);

endmodule

//--- load_store_unit.sv
`timescale 1ns/100ps
module load_store_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mop_valid,
    input  mem_op_t  mop,
    output logic     mop_ready,
    output logic     req_valid,
    output bus_req_t req,
    input  logic     req_ready,
    input  logic     rsp_valid,
    input  xlen_t    rsp_data,
    output logic     load_valid,
    output wb_t      load_wb
);
    mem_op_t op;
    logic    busy;

    // one op at a time from accept to response
    assign mop_ready = !busy;

    always_comb begin
        req.write = op.is_store;
        req.addr  = op.addr;
        req.wdata = op.wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            req_valid  <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            if (mop_valid && mop_ready) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            // store response completes silently
            load_valid <= busy && rsp_valid && !op.is_store;
            if (busy && rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mop_valid && mop_ready) begin
            op <= mop;
        end
        if (busy && rsp_valid) begin
            load_wb.rd   <= op.rd;
            load_wb.data <= rsp_data;
        end
    end

    // arbiter only routes a response after our request was taken
    a_rsp_owned: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> busy && !req_valid);

endmodule

//--- execute_unit.sv
`timescale 1ns/100ps
module execute_unit import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetch_valid,
    input  fetch_pkt_t fetch_pkt,
    output logic       fetch_ready,
    output logic       redirect,
    output xlen_t      redirect_pc,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    input  xlen_t      rdata1,
    input  xlen_t      rdata2,
    output logic       mop_valid,
    output mem_op_t    mop,
    input  logic       mop_ready,
    input  logic       load_valid,
    input  wb_t        load_wb,
    output logic       wb_valid,
    output wb_t        wb
);
    inst_t     inst;
    logic [6:0] opcode;
    reg_addr_t rd;
    xlen_t     imm_i;
    xlen_t     imm_s;
    xlen_t     imm_b;
    logic      is_alu;
    logic      is_load;
    logic      is_mem;
    xlen_t     alu_result;
    logic      sb_valid;
    reg_addr_t sb_rd;
    logic      hold_valid;
    wb_t       hold_wb;
    logic      accept;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign imm_i  = {{52{inst[31]}}, inst[31:20]};
    assign imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign is_alu  = (opcode == OP_IMM) || (opcode == OP_REG);
    assign is_load = (opcode == OP_LOAD);
    assign is_mem  = is_load || (opcode == OP_STORE);

    // add, sub or addi
    always_comb begin
        if (opcode == OP_REG && inst[31:25] == FUNCT7_SUB) begin
            alu_result = rdata1 - rdata2;
        end else if (opcode == OP_REG) begin
            alu_result = rdata1 + rdata2;
        end else begin
            alu_result = rdata1 + imm_i;
        end
    end

    // ------------------------------------------------------------
    // stall and accept
    // ------------------------------------------------------------
    // no accept while the buffered packet is on the wrong path or a result waits,
    // on a hit against the pending load or the register about to be written,
    // or while the memory op slot cannot take another op
    assign fetch_ready = !redirect && !hold_valid
        && !(sb_valid && (rs1 == sb_rd || rs2 == sb_rd || rd == sb_rd))
        && !(wb_valid && (rs1 == wb.rd || rs2 == wb.rd))
        && (!is_mem || ((!mop_valid || mop_ready) && !(is_load && sb_valid)));
    assign accept = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect   <= 1'b0;
            mop_valid  <= 1'b0;
            sb_valid   <= 1'b0;
            hold_valid <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            // taken beq
            redirect <= accept && (opcode == OP_BRANCH) && (rdata1 == rdata2);
            if (accept && is_mem) begin
                mop_valid <= 1'b1;
            end else if (mop_ready) begin
                mop_valid <= 1'b0;
            end
            // one-entry load scoreboard
            if (accept && is_load) begin
                sb_valid <= 1'b1;
            end else if (load_valid) begin
                sb_valid <= 1'b0;
            end
            // load data wins the writeback port, alu result waits a cycle
            hold_valid <= (hold_valid || (accept && is_alu)) && load_valid;
            wb_valid   <= load_valid || hold_valid || (accept && is_alu);
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= fetch_pkt.pc + imm_b;
        if (accept && is_mem) begin
            mop.is_store <= !is_load;
            mop.addr     <= rdata1 + (is_load ? imm_i : imm_s);
            mop.wdata    <= rdata2;
            mop.rd       <= rd;
        end
        if (accept && is_load) begin
            sb_rd <= rd;
        end
        if (accept && is_alu) begin
            hold_wb.rd   <= rd;
            hold_wb.data <= alu_result;
        end
        if (load_valid) begin
            wb <= load_wb;
        end else if (hold_valid) begin
            wb <= hold_wb;
        end else begin
            wb.rd   <= rd;
            wb.data <= alu_result;
        end
    end

    // a taken branch redirects for exactly one cycle
    a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !redirect);

    // a load handed to the lsu is the one held by the scoreboard
    a_one_load: assert property (@(posedge clk) disable iff (reset)
        mop_valid && mop_ready && !mop.is_store |-> sb_valid && sb_rd == mop.rd);

endmodule

//--- fetch_unit.sv
`timescale 1ns/100ps
module fetch_unit import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       redirect,
    input  xlen_t      redirect_pc,
    output logic       req_valid,
    output bus_req_t   req,
    input  logic       req_ready,
    input  logic       rsp_valid,
    input  xlen_t      rsp_data,
    output logic       fetch_valid,
    output fetch_pkt_t fetch_pkt,
    input  logic       fetch_ready
);
    xlen_t pc;
    xlen_t inflight_pc;
    logic  busy;
    logic  discard;
    logic  issue;

    // new request only when nothing is outstanding and the buffer frees up
    assign issue = !req_valid && !busy && (!fetch_valid || fetch_ready) && !redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= RESET_PC;
            req_valid   <= 1'b0;
            busy        <= 1'b0;
            discard     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (issue) begin
                req_valid <= 1'b1;
                pc        <= pc + 64'd4;
            end
            // request taken, now wait for the response
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                busy      <= 1'b1;
            end
            if (fetch_valid && fetch_ready) begin
                fetch_valid <= 1'b0;
            end
            if (busy && rsp_valid) begin
                busy        <= 1'b0;
                discard     <= 1'b0;
                fetch_valid <= !discard && !redirect;
            end
            // wrong path, flush buffer and mark the in-flight fetch
            if (redirect) begin
                pc          <= redirect_pc;
                fetch_valid <= 1'b0;
                discard     <= req_valid || (busy && !rsp_valid);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_pc <= pc;
            req.write   <= 1'b0;
            req.addr    <= {pc[63:3], 3'b000};
            req.wdata   <= '0;
        end
        // pc bit 2 picks the half of the 64-bit word
        if (busy && rsp_valid) begin
            fetch_pkt.pc   <= inflight_pc;
            fetch_pkt.inst <= inflight_pc[2] ? rsp_data[63:32] : rsp_data[31:0];
        end
    end

    // request held until the arbiter takes it
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> $stable(req));

endmodule

//--- reg_file.sv
`timescale 1ns/100ps
module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rdata1,
    output xlen_t     rdata2,
    input  logic      wb_valid,
    input  wb_t       wb
);
    xlen_t regs [32];

    // x0 is hardwired to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

//--- core_pkg.sv
package core_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct7 of sub, add uses all zeros
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    localparam xlen_t RESET_PC = 64'h0;

    // ------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------
    // one system bus request, valid and ready travel beside it
    typedef struct packed {
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } bus_req_t;

    // memory op from execute to the load/store unit
    typedef struct packed {
        logic      is_store;
        xlen_t     addr;
        xlen_t     wdata;
        reg_addr_t rd;
    } mem_op_t;

    // one register write
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    // instruction with the pc it was fetched from
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_D,
        ARB_WAIT_I
    } arb_state_t;

endpackage
